// File: sim.f
+incdir+hdl
hdl/flash_pkg.sv
hdl/flash_apb_regs.sv
hdl/page_latch.sv
hdl/memory_access.sv
hdl/flash_top.sv
dv/flash_tb_clk.sv
dv/flash_properties.sv
dv/flash_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the flash testbench with Verilator and run it
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module flash_tb \
   -Mdir obj_dir \
   -f sim.f
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "verilator build failed with status $build_status"
   exit $build_status
fi

./obj_dir/Vflash_tb
sim_status=$?
if [ $sim_status -ne 0 ]; then
   echo "simulation failed with status $sim_status"
   exit $sim_status
fi

exit 0

// File: dv/flash_tb.sv
// ------------------------------
// testbench for the flash model with its apb front end
// drives register sequences, mirrors the array in a reference model
// and compares every data, status and pslverr result
// ------------------------------
`timescale 1ns/1ns
`include "flash_macros.svh"

module flash_tb;

   import flash_pkg::*;

   localparam int TIMEOUT_CYCLES = 2000;
   // a bulk erase keeps the engine busy for one cycle per byte
   localparam int BULK_MIN_WAIT  = `FLASH_DEPTH - 4;

   logic                   se_enable;
   logic                   read_enable;
   logic [`APB_ADDR_W-1:0] paddr;
   logic                   psel;
   logic                   penable;
   logic                   pwrite;
   apb_data_t              pwdata;
   apb_data_t              prdata;
   logic                   pready;
   logic                   pslverr;

   // ------------------------------
   // reference state
   // ------------------------------
   flash_data_t mirror [`FLASH_DEPTH];
   flash_data_t lat_m [`FLASH_PAGE_LEN];
   flash_addr_t ptr_m;

   // results queued for the comparing process
   string       data_name_q[$];
   flash_data_t data_got_q[$];
   flash_data_t data_exp_q[$];
   string       err_name_q[$];
   logic        err_got_q[$];
   logic        err_exp_q[$];
   int          error_count;

   flash_tb_clk i_clk
   (
      .se_enable   (se_enable),
      .read_enable (read_enable)
   );

   flash_top i_dut
   (
      .se_enable   (se_enable),
      .read_enable (read_enable),
      .paddr       (paddr),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .pwdata      (pwdata),
      .prdata      (prdata),
      .pready      (pready),
      .pslverr     (pslverr)
   );

   // ------------------------------
   // error reporting and compares
   // ------------------------------
   task automatic stop_run();
      $display(">>> FAIL");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic report_timeout(input string what);
      error_count++;
      $display("timeout: %s did not finish within %0d cycles", what, TIMEOUT_CYCLES);
      stop_run();
   endtask

   task automatic compare_data(input string name, input flash_data_t got,
                               input flash_data_t exp);
      if (got !== exp)
      begin
         error_count++;
         $display("mismatch at %0t ns: %s got 0x%02h expected 0x%02h", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic compare_err(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         error_count++;
         $display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_back_pressure(input string what, input int waits);
      if (waits < BULK_MIN_WAIT)
      begin
         error_count++;
         $display("back-pressure failed: %s completed after %0d wait cycles, expected %0d",
                  what, waits, BULK_MIN_WAIT);
         stop_run();
      end
   endtask

   // comparing process drains whatever the driver queued
   always @(posedge se_enable)
   begin
      while (err_got_q.size() > 0)
      begin
         compare_err(err_name_q.pop_front(), err_got_q.pop_front(), err_exp_q.pop_front());
      end
      while (data_got_q.size() > 0)
      begin
         compare_data(data_name_q.pop_front(), data_got_q.pop_front(),
                      data_exp_q.pop_front());
      end
   end

   // ------------------------------
   // reference model
   // ------------------------------
   function automatic flash_data_t flash_model_read(input flash_addr_t a);
      return mirror[a];
   endfunction

   // AND the latch into the page holding the pointer, then empty the latch
   task automatic model_program();
      flash_addr_t base;
      base = ptr_m & ~flash_addr_t'(`FLASH_PAGE_LEN - 1);
      for (int i = 0; i < `FLASH_PAGE_LEN; i++)
      begin
         mirror[base + flash_addr_t'(i)] &= lat_m[i];
         lat_m[i] = '1;
      end
   endtask

   task automatic model_erase(input flash_op_t op);
      flash_addr_t base;
      int          len;
      base = ptr_m & ~flash_addr_t'(`FLASH_SECTOR_LEN - 1);
      len  = `FLASH_SECTOR_LEN;
      if (op == OP_BULK_ERASE)
      begin
         base = '0;
         len  = `FLASH_DEPTH;
      end
      for (int i = 0; i < len; i++)
      begin
         mirror[base + flash_addr_t'(i)] = '1;
      end
   endtask

   // ------------------------------
   // apb driver
   // ------------------------------
   // entered and left 1 ns after a rising edge
   task automatic apb_access(input logic [`APB_ADDR_W-1:0] a, input logic wr,
                             input apb_data_t d, output apb_data_t rd,
                             output logic err, output int waits);
      // setup phase
      paddr   = a;
      pwrite  = wr;
      pwdata  = d;
      psel    = 1'b1;
      penable = 1'b0;
      @(posedge se_enable);
      #1;
      penable = 1'b1;
      waits   = 0;
      // pready is sampled mid cycle where it has settled
      @(negedge se_enable);
      while (!pready)
      begin
         waits++;
         if (waits >= TIMEOUT_CYCLES)
         begin
            report_timeout($sformatf("apb access to offset 0x%02h", a));
         end
         @(negedge se_enable);
      end
      rd  = prdata;
      err = pslverr;
      @(posedge se_enable);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic reg_access(input logic [`APB_ADDR_W-1:0] a, input logic wr,
                             input apb_data_t d, input logic exp_err,
                             output apb_data_t rd, output int waits);
      logic err;
      apb_access(a, wr, d, rd, err, waits);
      err_name_q.push_back($sformatf("pslverr (%s 0x%02h)", wr ? "write" : "read", a));
      err_got_q.push_back(err);
      err_exp_q.push_back(exp_err);
   endtask

   // ------------------------------
   // register level helpers
   // ------------------------------
   task automatic set_ptr(input flash_addr_t a);
      apb_data_t rd;
      int        waits;
      reg_access(`REG_ADDR, 1'b1, apb_data_t'(a), 1'b0, rd, waits);
      ptr_m = a;
   endtask

   // pointer wraps inside the page after each latch write
   task automatic latch_write(input flash_data_t b);
      apb_data_t rd;
      int        waits;
      page_idx_t idx;
      reg_access(`REG_WDATA, 1'b1, apb_data_t'(b), 1'b0, rd, waits);
      idx        = page_idx_t'(ptr_m);
      lat_m[idx] = b;
      idx        = idx + 4'd1;
      ptr_m      = {ptr_m[`FLASH_ADDR_W-1:$bits(page_idx_t)], idx};
   endtask

   task automatic issue_cmd(input flash_op_t op, output int waits);
      apb_data_t rd;
      reg_access(`REG_CMD, 1'b1, apb_data_t'(op), 1'b0, rd, waits);
      if (op == OP_PROGRAM)
      begin
         model_program();
      end
      else
      begin
         model_erase(op);
      end
   endtask

   task automatic read_byte(output int waits);
      apb_data_t rd;
      reg_access(`REG_RDATA, 1'b0, '0, 1'b0, rd, waits);
      data_name_q.push_back($sformatf("prdata (array byte 0x%02h)", ptr_m));
      data_got_q.push_back(rd[`FLASH_DATA_W-1:0]);
      data_exp_q.push_back(flash_model_read(ptr_m));
      ptr_m = ptr_m + 8'd1;
   endtask

   task automatic read_status(input logic exp_busy);
      apb_data_t rd;
      int        waits;
      reg_access(`REG_STATUS, 1'b0, '0, 1'b0, rd, waits);
      data_name_q.push_back("prdata (status)");
      data_got_q.push_back(rd[`FLASH_DATA_W-1:0]);
      data_exp_q.push_back(flash_data_t'(exp_busy));
   endtask

   // poll status until the engine is idle
   task automatic wait_idle();
      apb_data_t rd;
      int        waits;
      int        polls;
      polls = 0;
      reg_access(`REG_STATUS, 1'b0, '0, 1'b0, rd, waits);
      while (rd[0])
      begin
         polls++;
         if (polls >= TIMEOUT_CYCLES / 2)
         begin
            report_timeout("wait for busy to clear");
         end
         reg_access(`REG_STATUS, 1'b0, '0, 1'b0, rd, waits);
      end
   endtask

   task automatic check_range(input flash_addr_t a, input int n);
      int waits;
      set_ptr(a);
      for (int i = 0; i < n; i++)
      begin
         read_byte(waits);
      end
   endtask

   task automatic program_page(input flash_addr_t a, input int n);
      int waits;
      set_ptr(a);
      for (int i = 0; i < n; i++)
      begin
         latch_write(flash_data_t'($urandom()));
      end
      issue_cmd(OP_PROGRAM, waits);
      wait_idle();
   endtask

   // ------------------------------
   // sequences
   // ------------------------------
   initial
   begin
      int        waits;
      int        cycles;
      apb_data_t rd;
      paddr       = '0;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      pwdata      = '0;
      error_count = 0;
      ptr_m       = '0;
      for (int i = 0; i < `FLASH_DEPTH; i++)
      begin
         mirror[i] = '1;
      end
      for (int i = 0; i < `FLASH_PAGE_LEN; i++)
      begin
         lat_m[i] = '1;
      end
      void'($urandom(32'h52d5_a56b));

      cycles = 0;
      while (read_enable !== 1'b0)
      begin
         @(posedge se_enable);
         cycles++;
         if (cycles >= TIMEOUT_CYCLES)
         begin
            report_timeout("reset release");
         end
      end
      @(posedge se_enable);
      #1;

      // array erased after reset with the pointer rolling over at the top
      read_status(1'b0);
      for (int i = 0; i < 16; i++)
      begin
         read_byte(waits);
      end
      check_range(8'd250, 12);

      // page program where 20 writes wrap inside the page at 0x20
      program_page(8'h23, 20);
      check_range(8'h10, 48);
      // latch is empty now, so programming an erased page leaves it erased
      set_ptr(8'h90);
      issue_cmd(OP_PROGRAM, waits);
      wait_idle();
      check_range(8'h80, 48);
      // old AND new on the same page
      program_page(8'h20, 16);
      check_range(8'h20, 16);
      // reads across the top of the array land on page zero
      program_page(8'h00, 16);
      check_range(8'hFA, 12);

      // sector erase from inside sector 1 only touches 0x40..0x7f
      program_page(8'h40, 16);
      program_page(8'h7C, 8);
      program_page(8'h80, 16);
      set_ptr(8'h6A);
      issue_cmd(OP_SECTOR_ERASE, waits);
      wait_idle();
      check_range(8'h00, 192);
      issue_cmd(OP_BULK_ERASE, waits);
      // status shows busy while the bulk erase runs
      read_status(1'b1);
      wait_idle();
      check_range(8'h00, `FLASH_DEPTH);

      // back-pressure on an array read right behind a bulk erase
      program_page(8'h10, 16);
      issue_cmd(OP_BULK_ERASE, waits);
      read_byte(waits);
      check_back_pressure("REG_RDATA read", waits);
      read_status(1'b0);
      // and on a command right behind a bulk erase
      program_page(8'h50, 16);
      issue_cmd(OP_BULK_ERASE, waits);
      issue_cmd(OP_SECTOR_ERASE, waits);
      check_back_pressure("REG_CMD write", waits);
      wait_idle();
      check_range(8'h40, 32);

      // bus errors leave array and pointer alone
      program_page(8'h30, 16);
      set_ptr(8'h35);
      reg_access(8'h14, 1'b1, 32'h0000_005A, 1'b1, rd, waits);
      reg_access(8'h20, 1'b0, '0, 1'b1, rd, waits);
      reg_access(`REG_CMD, 1'b1, '0, 1'b1, rd, waits);
      reg_access(`REG_STATUS, 1'b1, 32'h0000_0001, 1'b1, rd, waits);
      reg_access(`REG_RDATA, 1'b1, '0, 1'b1, rd, waits);
      read_status(1'b0);
      // pointer must still sit at 0x35
      for (int i = 0; i < 11; i++)
      begin
         read_byte(waits);
      end
      check_range(8'h00, `FLASH_DEPTH);

      cycles = 0;
      while (data_got_q.size() > 0 || err_got_q.size() > 0)
      begin
         @(posedge se_enable);
         cycles++;
         if (cycles >= TIMEOUT_CYCLES)
         begin
            report_timeout("result compare");
         end
      end
      if (error_count == 0)
      begin
         $display(">>> PASS");
         $finish;
      end
      else
      begin
         $display(">>> FAIL");
         $fatal(1, "errors found during the run");
      end
   end

endmodule

// File: dv/flash_properties.sv
// ------------------------------
// concurrent checks on the apb handshake and the engine handshake
// bound into the flash top level
// ------------------------------
`timescale 1ns/1ns
`include "flash_macros.svh"

module flash_properties
(
   input logic                   se_enable,
   input logic                   read_enable,
   input logic [`APB_ADDR_W-1:0] paddr,
   input logic                   psel,
   input logic                   penable,
   input logic                   pwrite,
   input logic                   pready,
   input logic                   start,
   input logic                   busy,
   input logic                   done
);

   // ------------------------------
   // engine handshake
   // ------------------------------
   // a new operation launches on an idle engine and makes it busy
   a_start_idle: assert property (@(posedge se_enable) disable iff (read_enable)
      start |=> (busy && !$past(busy)))
      else $error("start pulsed while busy or did not make the engine busy");

   // busy covers the done cycle and drops right after
   a_done_busy: assert property (@(posedge se_enable) disable iff (read_enable)
      done |=> !busy)
      else $error("busy still high in the cycle after done");

   // first cycle out of reset is quiet
   a_reset_quiet: assert property (@(posedge se_enable)
      $fell(read_enable) |-> (!start && !busy))
      else $error("start or busy high right after reset");

   // ------------------------------
   // apb handshake
   // ------------------------------
   // an array read always takes its wait state for the engine reply
   a_rdata_wait: assert property (@(posedge se_enable) disable iff (read_enable)
      (pready && !pwrite && (paddr == `REG_RDATA)) |-> $past(psel && penable))
      else $error("array read completed in its first access cycle");

endmodule

bind flash_top flash_properties i_props
(
   .se_enable   (se_enable),
   .read_enable (read_enable),
   .paddr       (paddr),
   .psel        (psel),
   .penable     (penable),
   .pwrite      (pwrite),
   .pready      (pready),
   .start       (start),
   .busy        (busy),
   .done        (done)
);

// File: dv/flash_tb_clk.sv
// ------------------------------
// clock and reset source for the flash testbench
// 8 ns clock, reset held high for the first 16 cycles
// ------------------------------
`timescale 1ns/1ns

module flash_tb_clk
(
   output logic se_enable,
   output logic read_enable
);

   localparam int HALF_PERIOD  = 4;
   localparam int RESET_CYCLES = 16;

   initial
   begin
      se_enable = 1'b0;
      forever #HALF_PERIOD se_enable = ~se_enable;
   end

   // release just after an edge so no flop sees it change on the edge
   initial
   begin
      read_enable = 1'b1;
      repeat (RESET_CYCLES) @(posedge se_enable);
      #1;
      read_enable = 1'b0;
   end

endmodule

// File: hdl/flash_top.sv
// ------------------------------
// top level of the flash model
// apb register block driving the page latch and the array engine
// ------------------------------
`timescale 1ns/1ns
`include "flash_macros.svh"

module flash_top
(
   input  logic                    se_enable,
   input  logic                    read_enable,
   input  logic [`APB_ADDR_W-1:0]  paddr,
   input  logic                    psel,
   input  logic                    penable,
   input  logic                    pwrite,
   input  flash_pkg::apb_data_t    pwdata,
   output flash_pkg::apb_data_t    prdata,
   output logic                    pready,
   output logic                    pslverr
);

   import flash_pkg::*;

   // ------------------------------
   // internal wiring
   // ------------------------------
   // operation handshake
   logic        start;
   flash_op_t   op;
   flash_addr_t op_addr;
   logic        busy;
   logic        done;
   // array reads
   logic        rd_req;
   flash_addr_t rd_addr;
   flash_data_t rd_data;
   logic        rd_valid;
   // page latch ports
   logic        lat_we;
   page_idx_t   lat_widx;
   flash_data_t lat_wdata;
   page_idx_t   lat_ridx;
   flash_data_t lat_rdata;

   flash_apb_regs i_regs
   (
      .se_enable   (se_enable),
      .read_enable (read_enable),
      .paddr       (paddr),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .pwdata      (pwdata),
      .prdata      (prdata),
      .pready      (pready),
      .pslverr     (pslverr),
      .start       (start),
      .op          (op),
      .op_addr     (op_addr),
      .busy        (busy),
      .done        (done),
      .rd_req      (rd_req),
      .rd_addr     (rd_addr),
      .rd_data     (rd_data),
      .rd_valid    (rd_valid),
      .lat_we      (lat_we),
      .lat_widx    (lat_widx),
      .lat_wdata   (lat_wdata)
   );

   page_latch i_latch
   (
      .se_enable   (se_enable),
      .read_enable (read_enable),
      .lat_we      (lat_we),
      .lat_widx    (lat_widx),
      .lat_wdata   (lat_wdata),
      .lat_ridx    (lat_ridx),
      .lat_rdata   (lat_rdata),
      .op          (op),
      .done        (done)
   );

   memory_access i_mem
   (
      .se_enable   (se_enable),
      .read_enable (read_enable),
      .start       (start),
      .op          (op),
      .op_addr     (op_addr),
      .busy        (busy),
      .done        (done),
      .rd_req      (rd_req),
      .rd_addr     (rd_addr),
      .rd_data     (rd_data),
      .rd_valid    (rd_valid),
      .lat_ridx    (lat_ridx),
      .lat_rdata   (lat_rdata)
   );

endmodule

// File: hdl/memory_access.sv
// ------------------------------
// flash storage array and its operation engine
// walks one byte per cycle for program, sector erase and bulk erase
// and serves single byte reads one cycle after the request
// ------------------------------
`timescale 1ns/1ns
`include "flash_macros.svh"

module memory_access
(
   input  logic                    se_enable,
   input  logic                    read_enable,
   input  logic                    start,
   input  flash_pkg::flash_op_t    op,
   input  flash_pkg::flash_addr_t  op_addr,
   output logic                    busy,
   output logic                    done,
   input  logic                    rd_req,
   input  flash_pkg::flash_addr_t  rd_addr,
   output flash_pkg::flash_data_t  rd_data,
   output logic                    rd_valid,
   output flash_pkg::page_idx_t    lat_ridx,
   input  flash_pkg::flash_data_t  lat_rdata
);

   import flash_pkg::*;

   localparam int IDX_W = $bits(page_idx_t);

   flash_data_t mem [`FLASH_DEPTH];

   logic        busy_q;
   logic        done_q;
   flash_op_t   run_op;
   flash_addr_t base_q;
   flash_addr_t cnt_q;

   logic        launch;
   logic        wr_en;
   flash_op_t   wr_op;
   flash_addr_t wr_addr;
   flash_data_t wr_data;

   // ------------------------------
   // geometry helpers
   // ------------------------------
   // first byte of the region touched by an operation
   function automatic flash_addr_t align_base(flash_op_t o, flash_addr_t a);
      case (o)
         OP_PROGRAM:      return a & ~flash_addr_t'(`FLASH_PAGE_LEN - 1);
         OP_SECTOR_ERASE: return a & ~flash_addr_t'(`FLASH_SECTOR_LEN - 1);
         default:         return '0;
      endcase
   endfunction

   // offset of the last byte in that region
   function automatic flash_addr_t last_offset(flash_op_t o);
      case (o)
         OP_PROGRAM:      return flash_addr_t'(`FLASH_PAGE_LEN - 1);
         OP_SECTOR_ERASE: return flash_addr_t'(`FLASH_SECTOR_LEN - 1);
         default:         return flash_addr_t'(`FLASH_DEPTH - 1);
      endcase
   endfunction

   // ------------------------------
   // write step
   // ------------------------------
   // byte 0 is written on the start edge itself, so a page of 16
   // finishes with done 16 cycles after start
   assign launch  = start && !busy_q && (op != OP_NONE);
   assign wr_en   = launch || (busy_q && !done_q);
   assign wr_op   = launch ? op : run_op;
   assign wr_addr = launch ? align_base(op, op_addr) : base_q + cnt_q;

   // base is page aligned, so the low address bits index the latch
   assign lat_ridx = wr_addr[IDX_W-1:0];

   // program only clears bits, erase sets the byte back to ff
   assign wr_data = (wr_op == OP_PROGRAM) ? (mem[wr_addr] & lat_rdata) : '1;

   // ------------------------------
   // storage array, erased on reset
   // ------------------------------
   always_ff @(posedge se_enable or posedge read_enable)
   begin
      if (read_enable)
      begin
         for (int i = 0; i < `FLASH_DEPTH; i++)
         begin
            mem[i] <= '1;
         end
      end
      else if (wr_en)
      begin
         mem[wr_addr] <= wr_data;
      end
   end

   // ------------------------------
   // engine control
   // ------------------------------
   always_ff @(posedge se_enable or posedge read_enable)
   begin
      if (read_enable)
      begin
         busy_q   <= 1'b0;
         done_q   <= 1'b0;
         run_op   <= OP_NONE;
         base_q   <= '0;
         cnt_q    <= '0;
         rd_valid <= 1'b0;
      end
      else
      begin
         rd_valid <= rd_req;
         if (launch)
         begin
            busy_q <= 1'b1;
            run_op <= op;
            base_q <= align_base(op, op_addr);
            cnt_q  <= flash_addr_t'(1);
         end
         else if (done_q)
         begin
            // busy covers the done cycle and drops right after
            busy_q <= 1'b0;
            done_q <= 1'b0;
         end
         else if (busy_q)
         begin
            if (cnt_q == last_offset(run_op))
            begin
               done_q <= 1'b1;
            end
            else
            begin
               cnt_q <= cnt_q + 1'b1;
            end
         end
      end
   end

   // read data, valid together with rd_valid
   always_ff @(posedge se_enable)
   begin
      if (rd_req)
      begin
         rd_data <= mem[rd_addr];
      end
   end

   assign busy = busy_q;
   assign done = done_q;

endmodule

// File: hdl/page_latch.sv
// ------------------------------
// page program buffer, one page of bytes
// written from the registers, read by the array engine
// ------------------------------
`timescale 1ns/1ns
`include "flash_macros.svh"

module page_latch
(
   input  logic                    se_enable,
   input  logic                    read_enable,
   input  logic                    lat_we,
   input  flash_pkg::page_idx_t    lat_widx,
   input  flash_pkg::flash_data_t  lat_wdata,
   input  flash_pkg::page_idx_t    lat_ridx,
   output flash_pkg::flash_data_t  lat_rdata,
   input  flash_pkg::flash_op_t    op,
   input  logic                    done
);

   import flash_pkg::*;

   flash_data_t lat [`FLASH_PAGE_LEN];
   logic        clear;

   // a finished program empties the buffer
   assign clear = done && (op == OP_PROGRAM);

   always_ff @(posedge se_enable or posedge read_enable)
   begin
      if (read_enable)
      begin
         for (int i = 0; i < `FLASH_PAGE_LEN; i++)
         begin
            lat[i] <= '1;
         end
      end
      else
      begin
         if (clear)
         begin
            for (int i = 0; i < `FLASH_PAGE_LEN; i++)
            begin
               lat[i] <= '1;
            end
         end
         // a byte written in the clear cycle survives it
         if (lat_we)
         begin
            lat[lat_widx] <= lat_wdata;
         end
      end
   end

   // combinational read for the program walk
   assign lat_rdata = lat[lat_ridx];

endmodule

// File: hdl/flash_apb_regs.sv
// ------------------------------
// apb slave of the flash model
// keeps the address pointer, decodes the register map, launches operations
// and stretches the access phase for array reads and busy commands
// ------------------------------
`timescale 1ns/1ns
`include "flash_macros.svh"

module flash_apb_regs
(
   input  logic                    se_enable,
   input  logic                    read_enable,
   input  logic [`APB_ADDR_W-1:0]  paddr,
   input  logic                    psel,
   input  logic                    penable,
   input  logic                    pwrite,
   input  flash_pkg::apb_data_t    pwdata,
   output flash_pkg::apb_data_t    prdata,
   output logic                    pready,
   output logic                    pslverr,
   output logic                    start,
   output flash_pkg::flash_op_t    op,
   output flash_pkg::flash_addr_t  op_addr,
   input  logic                    busy,
   input  logic                    done,
   output logic                    rd_req,
   output flash_pkg::flash_addr_t  rd_addr,
   input  flash_pkg::flash_data_t  rd_data,
   input  logic                    rd_valid,
   output logic                    lat_we,
   output flash_pkg::page_idx_t    lat_widx,
   output flash_pkg::flash_data_t  lat_wdata
);

   import flash_pkg::*;

   localparam int IDX_W = $bits(page_idx_t);

   flash_addr_t ptr;
   flash_op_t   op_q;
   flash_op_t   cmd_op;
   logic        cmd_ok;
   logic        access;
   page_idx_t   widx_next;

   assign access    = psel & penable;
   // command code straight from the bus, only 1..3 are legal
   assign cmd_op    = flash_op_t'(pwdata[1:0]);
   assign cmd_ok    = (pwdata[`APB_DATA_W-1:2] == '0) && (pwdata[1:0] != 2'd0);
   // the latch index wraps inside the page, upper pointer bits stay
   assign lat_widx  = ptr[IDX_W-1:0];
   assign widx_next = lat_widx + 1'b1;
   assign lat_wdata = pwdata[`FLASH_DATA_W-1:0];
   // operations and reads both work at the pointer
   assign op_addr   = ptr;
   assign rd_addr   = ptr;
   // the engine samples op together with start, later it sees the held code
   assign op        = start ? cmd_op : op_q;

   // ------------------------------
   // access decode
   // ------------------------------
   always_comb
   begin
      pready  = 1'b0;
      pslverr = 1'b0;
      prdata  = '0;
      start   = 1'b0;
      rd_req  = 1'b0;
      lat_we  = 1'b0;
      if (access)
      begin
         case (paddr)
            `REG_ADDR:
            begin
               pready = 1'b1;
               prdata = apb_data_t'(ptr);
            end
            `REG_WDATA:
            begin
               pready = 1'b1;
               lat_we = pwrite;
            end
            `REG_CMD:
            begin
               if (!pwrite)
               begin
                  // read back the operation in flight
                  pready = 1'b1;
                  prdata = apb_data_t'(op_q);
               end
               else if (!cmd_ok)
               begin
                  pready  = 1'b1;
                  pslverr = 1'b1;
               end
               else
               begin
                  // back-pressure until the engine is idle
                  pready = !busy;
                  start  = !busy;
               end
            end
            `REG_RDATA:
            begin
               if (pwrite)
               begin
                  pready  = 1'b1;
                  pslverr = 1'b1;
               end
               else if (rd_valid)
               begin
                  pready = 1'b1;
                  prdata = apb_data_t'(rd_data);
               end
               else
               begin
                  // one request per access, held off while busy
                  rd_req = !busy;
               end
            end
            `REG_STATUS:
            begin
               pready  = 1'b1;
               pslverr = pwrite;
               prdata  = apb_data_t'(busy);
            end
            default:
            begin
               pready  = 1'b1;
               pslverr = 1'b1;
            end
         endcase
      end
   end

   // ------------------------------
   // pointer and held operation
   // ------------------------------
   always_ff @(posedge se_enable or posedge read_enable)
   begin
      if (read_enable)
      begin
         ptr  <= '0;
         op_q <= OP_NONE;
      end
      else
      begin
         // an access flagged with pslverr leaves the pointer alone
         if (access && pready && !pslverr)
         begin
            case (paddr)
               `REG_ADDR:
               begin
                  if (pwrite)
                  begin
                     ptr <= pwdata[`FLASH_ADDR_W-1:0];
                  end
               end
               `REG_WDATA:
               begin
                  if (pwrite)
                  begin
                     ptr <= {ptr[`FLASH_ADDR_W-1:IDX_W], widx_next};
                  end
               end
               `REG_RDATA:
               begin
                  // rolls over from the top of the array to zero
                  ptr <= ptr + 1'b1;
               end
               default:
               begin
                  ptr <= ptr;
               end
            endcase
         end
         // op_q stays valid through the done cycle for the page latch
         if (start)
         begin
            op_q <= cmd_op;
         end
         else if (done)
         begin
            op_q <= OP_NONE;
         end
      end
   end

endmodule

// File: hdl/flash_pkg.sv
// ------------------------------
// shared types for the flash array and its apb front end
// modules import it inside their body, ports use scoped names
// ------------------------------
`include "flash_macros.svh"

package flash_pkg;

   // ------------------------------
   // operations run by the array engine
   // ------------------------------
   // codes 1..3 written to the cmd register map onto these directly
   typedef enum logic [1:0]
   {
      OP_NONE         = 2'd0,
      OP_PROGRAM      = 2'd1,
      OP_SECTOR_ERASE = 2'd2,
      OP_BULK_ERASE   = 2'd3
   } flash_op_t;

   // ------------------------------
   // data and address types
   // ------------------------------
   // one array byte
   typedef logic [`FLASH_DATA_W-1:0] flash_data_t;
   // byte address into the array
   typedef logic [`FLASH_ADDR_W-1:0] flash_addr_t;
   // byte index inside a page
   typedef logic [$clog2(`FLASH_PAGE_LEN)-1:0] page_idx_t;
   // apb data word
   typedef logic [`APB_DATA_W-1:0] apb_data_t;

endpackage

// File: hdl/flash_macros.svh
// ------------------------------
// flash array geometry, apb bus widths and register offsets
// included by the package and by every rtl block that needs sizes
// ------------------------------
`ifndef FLASH_MACROS_SVH
`define FLASH_MACROS_SVH

// array geometry, sizes in bytes
`define FLASH_DATA_W      8
`define FLASH_ADDR_W      8
`define FLASH_DEPTH       256
`define FLASH_PAGE_LEN    16
`define FLASH_SECTOR_LEN  64

// apb bus
`define APB_ADDR_W        8
`define APB_DATA_W        32

// register offsets
`define REG_ADDR          8'h00
`define REG_WDATA         8'h04
`define REG_CMD           8'h08
`define REG_RDATA         8'h0C
`define REG_STATUS        8'h10

`endif
